//--- design/sprite_consts.svh
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// Entries in the object table
`define OBJ_COUNT 32

// Sprites are square, this many pixels on each side
`define OBJ_ROWS 16

// Graphics ROM word address width
`define ROM_AW 13

// Visible pixels per line and depth of each line buffer half
`define LINE_W 256

`endif

//--- design/sprite_pkg.sv
package sprite_pkg;

    // CPU access to object RAM, addr[6] picks the bank
    typedef struct packed {
        logic [6:0] addr;
        logic [7:0] wdata;
        logic       we;
    } cpu_bus_t;

    // Decoded table entry
    typedef struct packed {
        logic [7:0] attr;
        logic [7:0] ypos;
        logic [7:0] xpos;
        logic [7:0] code;
    } obj_entry_t;

    // Request from scanner to drawer
    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
        logic [7:0] xpos;
        logic [3:0] pal;
        logic       hflip;
    } draw_req_t;

    typedef logic [3:0] color_t;

    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        color_t     color;
    } buf_wr_t;

    typedef enum logic [1:0] {SCAN_IDLE, SCAN_EVEN, SCAN_ODD, SCAN_WAIT} scan_state_t;
    typedef enum logic [1:0] {DRAW_IDLE, DRAW_FETCH, DRAW_SHIFT} draw_state_t;

endpackage

//--- design/obj_ram.sv
`include "sprite_consts.svh"

module obj_ram import sprite_pkg::*; (
    input  logic       clk,
    input  cpu_bus_t   cpu,
    output logic [7:0] cpu_rdata,
    input  logic [5:0] scan_addr,
    output logic [7:0] bank0_q,
    output logic [7:0] bank1_q
);

    // Bank 0 holds attr and inverted y, bank 1 holds x and code
    logic [7:0] bank0 [0:2*`OBJ_COUNT-1];
    logic [7:0] bank1 [0:2*`OBJ_COUNT-1];
    logic [5:0] cpu_byte;

    assign cpu_byte = cpu.addr[5:0];

    // CPU port
    always_ff @(posedge clk) begin
        if (cpu.we && !cpu.addr[6]) begin
            bank0[cpu_byte] <= cpu.wdata;
        end
        if (cpu.we && cpu.addr[6]) begin
            bank1[cpu_byte] <= cpu.wdata;
        end
        cpu_rdata <= cpu.addr[6] ? bank1[cpu_byte] : bank0[cpu_byte];
    end

    // Scanner port, both banks at once
    always_ff @(posedge clk) begin
        bank0_q <= bank0[scan_addr];
        bank1_q <= bank1[scan_addr];
    end

endmodule

//--- design/obj_scan.sv
`include "sprite_consts.svh"

module obj_scan import sprite_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       hinit,
    input  logic [7:0] vrender,
    output logic [5:0] scan_addr,
    input  logic [7:0] bank0_q,
    input  logic [7:0] bank1_q,
    input  logic       dr_busy,
    output logic       dr_start,
    output draw_req_t  req
);

    scan_state_t state;
    logic [4:0]  idx;
    logic [7:0]  attr_q;
    logic [7:0]  xpos_q;
    obj_entry_t  cur;
    logic [7:0]  ydiff;
    logic        inzone;
    logic        last;
    logic        issue;

    // Odd byte is addressed one cycle ahead of its use and held in SCAN_ODD
    assign scan_addr = {idx, state == SCAN_EVEN || state == SCAN_ODD};

    assign cur    = '{attr: attr_q, ypos: ~bank0_q, xpos: xpos_q, code: bank1_q};
    assign ydiff  = vrender - cur.ypos;
    // Wraps in 8 bits, so y near 255 still covers lines 0..
    assign inzone = ydiff < 8'(`OBJ_ROWS);
    assign last   = idx == 5'(`OBJ_COUNT - 1);
    assign issue  = state == SCAN_ODD && !(inzone && dr_busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SCAN_IDLE;
            idx      <= '0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            if (hinit) begin
                idx   <= '0;
                state <= SCAN_WAIT;
            end else begin
                case (state)
                    SCAN_WAIT: state <= SCAN_EVEN;
                    SCAN_EVEN: state <= SCAN_ODD;
                    SCAN_ODD: begin
                        // Hold the entry until the drawer is free
                        if (issue) begin
                            dr_start <= inzone;
                            idx      <= idx + 5'd1;
                            state    <= last ? SCAN_IDLE : SCAN_WAIT;
                        end
                    end
                    default: state <= SCAN_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN_EVEN) begin
            attr_q <= bank0_q;
            xpos_q <= bank1_q;
        end
        if (issue && inzone) begin
            req.code  <= cur.code;
            req.row   <= ydiff[3:0] ^ {4{cur.attr[7]}};
            req.xpos  <= cur.xpos;
            req.pal   <= cur.attr[3:0];
            req.hflip <= cur.attr[6];
        end
    end

    // Drawer takes one sprite at a time
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        !(dr_start && dr_busy));

endmodule

//--- design/obj_palette.sv
module obj_palette import sprite_pkg::*; (
    input  logic       clk,
    input  logic       prog_en,
    input  logic [7:0] prog_addr,
    input  logic [3:0] prog_data,
    input  logic [7:0] lookup_addr,
    output color_t     color
);

    // Index is {palette bank, pixel nibble}
    color_t prom [0:255];

    always_ff @(posedge clk) begin
        if (prog_en) begin
            prom[prog_addr] <= prog_data;
        end
        color <= prom[lookup_addr];
    end

endmodule

//--- design/obj_draw.sv
`include "sprite_consts.svh"

module obj_draw import sprite_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               dr_start,
    input  draw_req_t          req,
    output logic               dr_busy,
    output logic               rom_cs,
    output logic [`ROM_AW-1:0] rom_addr,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok,
    output logic [7:0]         lookup_addr,
    input  color_t             color,
    output buf_wr_t            wr
);

    draw_state_t state;
    draw_req_t   cur;
    logic [31:0] pix;
    logic [2:0]  cnt;
    logic [7:0]  x;
    logic [7:0]  x_d;
    logic        pend;
    logic        accept;
    logic        last_half;

    assign accept      = state == DRAW_IDLE && !dr_busy && dr_start;
    // First half fetched is the one equal to hflip
    assign last_half   = rom_addr[0] != cur.hflip;
    assign lookup_addr = {cur.pal, pix[3:0]};

    // Palette output lines up with the delayed x
    assign wr = '{we: pend && color != 4'd0, addr: x_d, color: color};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= DRAW_IDLE;
            dr_busy <= 1'b0;
            rom_cs  <= 1'b0;
            cnt     <= '0;
            pend    <= 1'b0;
        end else begin
            pend <= state == DRAW_SHIFT;
            case (state)
                DRAW_IDLE: begin
                    if (dr_busy) begin
                        // Last pixel write happens in this cycle
                        dr_busy <= 1'b0;
                    end else if (dr_start) begin
                        dr_busy <= 1'b1;
                        rom_cs  <= 1'b1;
                        state   <= DRAW_FETCH;
                    end
                end
                DRAW_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                        state  <= DRAW_SHIFT;
                    end
                end
                DRAW_SHIFT: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'd7) begin
                        if (last_half) begin
                            state <= DRAW_IDLE;
                        end else begin
                            rom_cs <= 1'b1;
                            state  <= DRAW_FETCH;
                        end
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        x_d <= x;
        if (accept) begin
            cur      <= req;
            rom_addr <= {req.code, req.row, req.hflip};
        end
        if (state == DRAW_SHIFT && cnt == 3'd7 && !last_half) begin
            rom_addr[0] <= ~rom_addr[0];
        end
        if (state == DRAW_FETCH && rom_ok) begin
            pix <= rom_data;
            // Start column of this half, counting down when mirrored
            if (cur.hflip) begin
                x <= cur.xpos + {~rom_addr[0], 3'b111};
            end else begin
                x <= cur.xpos + {rom_addr[0], 3'b000};
            end
        end else if (state == DRAW_SHIFT) begin
            pix <= pix >> 4;
            x   <= cur.hflip ? x - 8'd1 : x + 8'd1;
        end
    end

    // ROM sees a steady request until rom_ok
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr));

endmodule

//--- design/line_buffer.sv
`include "sprite_consts.svh"

module line_buffer import sprite_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       LHBL,
    input  logic       pxl_cen,
    input  logic [7:0] hdump,
    input  buf_wr_t    wr,
    output color_t     pxl
);

    // Half sel is drawn, the other half is on screen
    color_t mem [0:1][0:`LINE_W-1];
    logic   sel;
    logic   lhbl_l;
    logic   rd_en;

    assign rd_en = pxl_cen && LHBL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l <= 1'b0;
            sel    <= 1'b0;
            pxl    <= '0;
        end else begin
            lhbl_l <= LHBL;
            // Swap at the start of blanking
            if (lhbl_l && !LHBL) begin
                sel <= ~sel;
            end
            if (rd_en) begin
                pxl <= mem[~sel][hdump];
            end
        end
    end

    // Reads erase so the half comes back clean for drawing
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[sel][wr.addr] <= wr.color;
        end
        if (rd_en) begin
            mem[~sel][hdump] <= 4'd0;
        end
    end

    // Transparent pixels are filtered out by the drawer
    a_no_clear_write: assert property (@(posedge clk) disable iff (rst)
        wr.we |-> wr.color != 4'd0);

endmodule

//--- design/sprite_engine.sv
`include "sprite_consts.svh"

module sprite_engine import sprite_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  cpu_bus_t           cpu,
    output logic [7:0]         cpu_rdata,
    input  logic               LHBL,
    input  logic               pxl_cen,
    input  logic [7:0]         hdump,
    input  logic [7:0]         vrender,
    input  logic               prog_en,
    input  logic [7:0]         prog_addr,
    input  logic [3:0]         prog_data,
    output logic               rom_cs,
    output logic [`ROM_AW-1:0] rom_addr,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok,
    output color_t             pxl
);

    logic [5:0] scan_addr;
    logic [7:0] bank0_q;
    logic [7:0] bank1_q;
    logic       dr_start;
    logic       dr_busy;
    draw_req_t  req;
    logic [7:0] lookup_addr;
    color_t     color;
    buf_wr_t    wr;
    logic       lhbl_l;
    logic       hinit;

    // Scan starts on the same edge that swaps the line buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l <= 1'b0;
        end else begin
            lhbl_l <= LHBL;
        end
    end

    assign hinit = lhbl_l && !LHBL;

    obj_ram u_ram (
        .clk(clk), .cpu(cpu), .cpu_rdata(cpu_rdata),
        .scan_addr(scan_addr), .bank0_q(bank0_q), .bank1_q(bank1_q)
    );

    obj_scan u_scan (
        .clk(clk), .rst(rst), .hinit(hinit), .vrender(vrender),
        .scan_addr(scan_addr), .bank0_q(bank0_q), .bank1_q(bank1_q),
        .dr_busy(dr_busy), .dr_start(dr_start), .req(req)
    );

    obj_palette u_palette (
        .clk(clk), .prog_en(prog_en), .prog_addr(prog_addr),
        .prog_data(prog_data), .lookup_addr(lookup_addr), .color(color)
    );

    obj_draw u_draw (
        .clk(clk), .rst(rst), .dr_start(dr_start), .req(req), .dr_busy(dr_busy),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .lookup_addr(lookup_addr), .color(color), .wr(wr)
    );

    line_buffer u_buffer (
        .clk(clk), .rst(rst), .LHBL(LHBL), .pxl_cen(pxl_cen),
        .hdump(hdump), .wr(wr), .pxl(pxl)
    );

endmodule

//--- test/sprite_engine_tb.sv
`include "sprite_consts.svh"

module sprite_engine_tb import sprite_pkg::*; ();

    logic               clk;
    logic               rst;
    cpu_bus_t           cpu;
    logic [7:0]         cpu_rdata;
    logic               LHBL;
    logic               pxl_cen;
    logic [7:0]         hdump;
    logic [7:0]         vrender;
    logic               prog_en;
    logic [7:0]         prog_addr;
    logic [3:0]         prog_data;
    logic               rom_cs;
    logic [`ROM_AW-1:0] rom_addr;
    logic [31:0]        rom_data;
    logic               rom_ok;
    color_t             pxl;

    // Record is {op, 16-bit field, 32-bit field}
    logic [51:0] recs [0:255];
    logic [31:0] rom_mem [0:(1<<`ROM_AW)-1];
    color_t      cap [0:`LINE_W-1];
    color_t      expv [0:`LINE_W-1];
    int          n_rec;
    int          byte_errs;
    int          color_errs;
    int          seed;
    int          lat;
    logic        waiting;

    sprite_engine uut (
        .clk(clk), .rst(rst), .cpu(cpu), .cpu_rdata(cpu_rdata),
        .LHBL(LHBL), .pxl_cen(pxl_cen), .hdump(hdump), .vrender(vrender),
        .prog_en(prog_en), .prog_addr(prog_addr), .prog_data(prog_data),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data),
        .rom_ok(rom_ok), .pxl(pxl)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ROM model with a random wait before each answer
    always @(posedge clk) begin
        if (rst) begin
            rom_ok  <= 1'b0;
            waiting = 1'b0;
        end else begin
            rom_ok <= 1'b0;
            if (rom_cs && !rom_ok) begin
                if (!waiting) begin
                    waiting = 1'b1;
                    lat = int'($unsigned($random(seed)) % 4);
                end
                if (lat == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_mem[rom_addr];
                    waiting = 1'b0;
                end else begin
                    lat = lat - 1;
                end
            end
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            byte_errs++;
            $display("[ERROR] t=%0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp) begin
            color_errs++;
            $display("[ERROR] t=%0t %s got %01h expected %01h", $time, name, got, exp);
        end
    endtask

    task automatic load_palette(input logic [7:0] a, input logic [3:0] d);
        @(posedge clk);
        prog_en   <= 1'b1;
        prog_addr <= a;
        prog_data <= d;
        @(posedge clk);
        prog_en <= 1'b0;
    endtask

    task automatic cpu_write(input logic [6:0] a, input logic [7:0] d);
        @(posedge clk);
        cpu <= '{addr: a, wdata: d, we: 1'b1};
        @(posedge clk);
        cpu <= '{addr: a, wdata: d, we: 1'b0};
    endtask

    task automatic cpu_readback(input logic [6:0] a, input logic [7:0] exp);
        @(posedge clk);
        cpu <= '{addr: a, wdata: 8'h00, we: 1'b0};
        @(posedge clk);
        @(negedge clk);
        check_byte($sformatf("cpu_rdata[%02h]", a), cpu_rdata, exp);
    endtask

    // One line period that opens with blanking so its falling edge starts the scan
    task automatic run_line(input logic [7:0] v);
        int h;
        for (int i = 0; i < 384; i++) begin
            h = (i + 256) % 384;
            @(posedge clk);
            if (i == 0) begin
                vrender <= v;
            end
            hdump   <= h[7:0];
            LHBL    <= h < 256;
            pxl_cen <= 1'b1;
            @(posedge clk);
            pxl_cen <= 1'b0;
            @(negedge clk);
            if (h < 256) begin
                cap[h] = pxl;
            end
            // Two idle clocks complete the four-clock pixel
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic compare_line();
        for (int x = 0; x < `LINE_W; x++) begin
            check_color($sformatf("pxl[%0d]", x), cap[x], expv[x]);
        end
    endtask

    task automatic clear_expected();
        for (int x = 0; x < `LINE_W; x++) begin
            expv[x] = 4'd0;
        end
    endtask

    // Watchdog sized from the record count
    initial begin
        wait (n_rec != 0);
        #((n_rec + 4) * 2000 * 40);
        $display("Timeout: simulation did not finish within the time budget");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [3:0]  op;
        logic [15:0] fa;
        logic [31:0] fd;
        logic        pending;
        int          k;

        seed       = 32'hd8c0_8223;
        byte_errs  = 0;
        color_errs = 0;
        n_rec      = 0;
        waiting    = 1'b0;
        lat        = 0;
        pending    = 1'b0;
        rst        = 1'b1;
        cpu        = '{addr: 7'd0, wdata: 8'd0, we: 1'b0};
        LHBL       = 1'b1;
        pxl_cen    = 1'b0;
        hdump      = 8'd0;
        vrender    = 8'h80;
        prog_en    = 1'b0;
        prog_addr  = 8'd0;
        prog_data  = 4'd0;
        rom_data   = 32'd0;
        rom_ok     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            recs[i] = '0;
        end
        for (int i = 0; i < (1 << `ROM_AW); i++) begin
            rom_mem[i] = 32'd0;
        end
        clear_expected();
        $readmemh("test/sprite_testdata.txt", recs);
        while (n_rec < 256 && recs[n_rec][51:48] != 4'd0) begin
            n_rec++;
        end
        if (n_rec == 0) begin
            $display("No records found in the test data file");
            $display("=== FAIL ===");
            $finish;
        end else begin
            repeat (16) @(posedge clk);
            rst <= 1'b0;

            // Two empty lines leave both buffer halves erased
            run_line(8'h80);
            run_line(8'h80);

            for (k = 0; k < n_rec; k++) begin
                op = recs[k][51:48];
                fa = recs[k][47:32];
                fd = recs[k][31:0];
                case (op)
                    4'd1: load_palette(fa[7:0], fd[3:0]);
                    4'd2: cpu_write(fa[6:0], fd[7:0]);
                    4'd3: cpu_readback(fa[6:0], fd[7:0]);
                    4'd4: rom_mem[fa[`ROM_AW-1:0]] = fd;
                    4'd5: begin
                        // This line shows what the previous L record drew
                        run_line(fa[7:0]);
                        if (pending) begin
                            compare_line();
                        end
                        clear_expected();
                        pending = 1'b1;
                    end
                    4'd6: expv[fa[7:0]] = fd[3:0];
                    default: begin
                        $display("Unknown record type %0d at record %0d", op, k);
                        byte_errs++;
                    end
                endcase
            end
            if (pending) begin
                run_line(8'h80);
                compare_line();
            end

            $display("Checks done: %0d byte errors, %0d color errors", byte_errs, color_errs);
            if (byte_errs == 0 && color_errs == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

//--- test/sprite_testdata.txt
// op_aaaa_dddddddd  op 1 palette, 2 cpu write, 3 cpu readback, 4 rom word
// op 5 line at vrender aaaa, op 6 expected colour dddddddd at x aaaa
1_0011_0000000A 1_0012_0000000B 1_0013_0000000C
1_0014_0000000D 1_0021_00000005 1_0022_00000006
4_00A4_00000321 4_00A5_40000000 4_00FC_00000021 4_00FD_10000000
4_00C4_00000004 4_00C5_03000000 4_0104_20000000 4_0105_00000001
// Entry 0 plain at y 40, entry 1 flipped at y 60
2_0000_00000001 2_0001_000000BF 2_0040_00000020 2_0041_00000005
2_0002_000000C2 2_0003_0000009F 2_0042_00000080 2_0043_00000007
3_0001_000000BF 3_0041_00000005 3_0002_000000C2 3_0042_00000080
// Single sprite on line 42
5_0042_00000000
6_0020_0000000A 6_0021_0000000B 6_0022_0000000C 6_002F_0000000D
// Entry 2 overlaps entry 0, entry 3 wraps from x 250
2_0004_00000001 2_0005_000000BF 2_0044_00000021 2_0045_00000006
2_0006_00000002 2_0007_000000BF 2_0046_000000FA 2_0047_00000008
3_0045_00000006 3_0006_00000002
5_0042_00000000
6_0020_0000000A 6_0021_0000000D 6_0022_0000000C 6_002F_0000000C
6_0001_00000006 6_0002_00000005
// Empty line, then the mirrored sprite on line 61
5_0010_00000000
5_0061_00000000
6_008F_00000005 6_008E_00000006 6_0080_00000005

//--- sprite_engine.f
+incdir+design
design/sprite_pkg.sv
design/obj_ram.sv
design/obj_scan.sv
design/obj_palette.sv
design/obj_draw.sv
design/line_buffer.sv
design/sprite_engine.sv
test/sprite_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sprite_engine_tb -f sprite_engine.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/Vsprite_engine_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1
